// File: list.f
source/l15_adapter_pkg.sv
source/one_entry_buffer.sv
source/icache_miss_port.sv
source/l15_req_arbiter.sv
source/l15_resp_demux.sv
source/l15_adapter_top.sv
verification/tb_clock_gen.sv
verification/l15_adapter_tb.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= l15_adapter_tb
RTL_TOP   ?= l15_adapter_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/l15_adapter_tb.sv
`timescale 1ns/1ps

module l15_adapter_tb import l15_adapter_pkg::*; ();

  // Whole run is about a hundred cycles
  localparam int TEST_CYCLES = 100;
  localparam int MAX_CYCLES  = 20 * TEST_CYCLES;

  logic         clk_i;
  logic         arst_n_i;
  logic         icache_miss_valid_i;
  logic         icache_miss_ready_o;
  icache_miss_t icache_miss_i;
  logic         icache_rtrn_valid_o;
  icache_rtrn_t icache_rtrn_o;
  logic         dread_valid_i;
  logic         dread_ready_o;
  mem_req_t     dread_req_i;
  logic         wreq_valid_i;
  logic         wdata_valid_i;
  logic         wreq_ready_o;
  mem_req_t     wreq_i;
  mem_wdata_t   wdata_i;
  logic         dread_resp_valid_o;
  logic         dread_resp_ready_i;
  mem_resp_t    dread_resp_o;
  logic         dwrite_resp_valid_o;
  logic         dwrite_resp_ready_i;
  mem_resp_t    dwrite_resp_o;
  logic         mem_req_valid_o;
  logic         mem_req_ready_i;
  l15_req_t     mem_req_o;
  logic         mem_resp_valid_i;
  logic         mem_resp_ready_o;
  mem_resp_t    mem_resp_i;

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_q;
  logic        acc_dread_rdy;
  logic        acc_wreq_rdy;

  tb_clock_gen #(
    .PERIOD_NS (40)
  ) u_clock_gen (
    .clk_o (clk_i)
  );

  l15_adapter_top l15_adapter_top_inst (.*);

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  // Galois form with taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [MEM_DATA_W-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v[i]   = lfsr_q[0];
    end
  endtask

  task automatic check_req(input string name, input l15_req_t got, input l15_req_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input mem_resp_t got, input mem_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_rtrn(input string name, input icache_rtrn_t got,
                            input icache_rtrn_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("[%0t] %s: ok", $time, name);
    end else begin
      $display("[%0t] %s: %0d mismatches", $time, name, errors - errs_before);
    end
  endtask

  // Read of line or word size built from the miss
  function automatic l15_req_t exp_icache_req(input icache_miss_t miss);
    l15_req_t r;
    r               = '0;
    r.port_id       = PORT_ICACHE;
    r.req.addr      = miss.paddr;
    r.req.size      = miss.nc ? 3'd3 : 3'd4;
    r.req.id        = miss.tid;
    r.req.cmd       = MEM_READ;
    r.req.cacheable = !miss.nc;
    return r;
  endfunction

  function automatic l15_req_t exp_dcache_req(input port_id_t port, input mem_req_t req,
                                              input mem_wdata_t wdata);
    l15_req_t r;
    r.port_id = port;
    r.req     = req;
    r.wdata   = wdata;
    return r;
  endfunction

  function automatic logic resp_valid(input port_id_t port);
    case (port)
      PORT_ICACHE: return icache_rtrn_valid_o;
      PORT_DREAD:  return dread_resp_valid_o;
      default:     return dwrite_resp_valid_o;
    endcase
  endfunction

  task automatic rand_req(input mem_cmd_e cmd, input logic [2:0] size,
                          input logic [MEM_ID_W-1:0] id, output mem_req_t r);
    logic [MEM_DATA_W-1:0] bits;
    rand_bits(PADDR_W, bits);
    r.addr      = bits[PADDR_W-1:0];
    r.size      = size;
    r.id        = id;
    r.cmd       = cmd;
    r.cacheable = 1'b1;
  endtask

  task automatic read_resp(input port_id_t port, input logic [MEM_ID_W-1:0] id,
                           output mem_resp_t rsp);
    logic [MEM_DATA_W-1:0] bits;
    rand_bits(MEM_DATA_W, bits);
    rsp         = '0;
    rsp.port_id = port;
    rsp.id      = id;
    rsp.data    = bits;
  endtask

  task automatic idle_inputs();
    icache_miss_valid_i = 1'b0;
    dread_valid_i       = 1'b0;
    wreq_valid_i        = 1'b0;
    wdata_valid_i       = 1'b0;
    mem_req_ready_i     = 1'b0;
    mem_resp_valid_i    = 1'b0;
    dread_resp_ready_i  = 1'b1;
    dwrite_resp_ready_i = 1'b1;
  endtask

  task automatic apply_reset();
    idle_inputs();
    arst_n_i = 1'b0;
    repeat (3) @(negedge clk_i);
    arst_n_i = 1'b1;
  endtask

  // Request side of the memory model. Entered on a falling edge
  task automatic mem_accept(output l15_req_t req);
    mem_req_ready_i = 1'b1;
    #1;
    while (!mem_req_valid_o) begin
      @(negedge clk_i);
      #1;
    end
    req           = mem_req_o;
    acc_dread_rdy = dread_ready_o;
    acc_wreq_rdy  = wreq_ready_o;
    @(negedge clk_i);
    mem_req_ready_i = 1'b0;
  endtask

  // Response side of the memory model. Returns 1 ns after the falling edge
  task automatic mem_respond(input mem_resp_t rsp);
    mem_resp_valid_i = 1'b1;
    mem_resp_i       = rsp;
    #1;
    while (!mem_resp_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    mem_resp_valid_i = 1'b0;
    #1;
  endtask

  task automatic wait_resp(input port_id_t port);
    while (!resp_valid(port)) begin
      @(negedge clk_i);
      #1;
    end
  endtask

  task automatic send_miss(input icache_miss_t miss);
    icache_miss_valid_i = 1'b1;
    icache_miss_i       = miss;
    #1;
    while (!icache_miss_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    icache_miss_valid_i = 1'b0;
  endtask

  task automatic test_icache_fill();
    int                    errs;
    icache_miss_t          miss;
    l15_req_t              got;
    mem_resp_t             rsp;
    icache_rtrn_t          exp_rtrn;
    logic [MEM_DATA_W-1:0] bits;
    errs = errors;
    // Cacheable line fill first, then a single word fetch
    for (int nc = 0; nc < 2; nc++) begin
      rand_bits(PADDR_W, bits);
      miss.paddr = bits[PADDR_W-1:0];
      miss.nc    = 1'(nc);
      miss.tid   = 4'(3 + nc);
      @(negedge clk_i);
      send_miss(miss);
      // Held miss blocks the cache until the memory takes the read
      #1;
      check_flag("icache_miss_ready_o", icache_miss_ready_o, 1'b0);
      mem_accept(got);
      check_req("mem_req_o", got, exp_icache_req(miss));
      read_resp(PORT_ICACHE, miss.tid, rsp);
      mem_respond(rsp);
      wait_resp(PORT_ICACHE);
      exp_rtrn.rtype = ICACHE_IFILL_ACK;
      exp_rtrn.data  = rsp.data;
      exp_rtrn.tid   = miss.tid;
      check_rtrn("icache_rtrn_o", icache_rtrn_o, exp_rtrn);
    end
    end_test("icache fill", errs);
  endtask

  task automatic test_dread();
    int        errs;
    mem_req_t  dreq;
    l15_req_t  got;
    mem_resp_t rsp;
    errs = errors;
    rand_req(MEM_READ, 3'd3, 4'd9, dreq);
    @(negedge clk_i);
    dread_valid_i = 1'b1;
    dread_req_i   = dreq;
    mem_accept(got);
    dread_valid_i = 1'b0;
    check_flag("dread_ready_o", acc_dread_rdy, 1'b1);
    check_req("mem_req_o", got, exp_dcache_req(PORT_DREAD, dreq, '0));
    read_resp(PORT_DREAD, dreq.id, rsp);
    mem_respond(rsp);
    wait_resp(PORT_DREAD);
    check_resp("dread_resp_o", dread_resp_o, rsp);
    check_flag("icache_rtrn_valid_o", icache_rtrn_valid_o, 1'b0);
    check_flag("dwrite_resp_valid_o", dwrite_resp_valid_o, 1'b0);
    @(negedge clk_i);
    #1;
    check_flag("dread_resp_valid_o", dread_resp_valid_o, 1'b0);
    end_test("dcache read miss", errs);
  endtask

  task automatic test_write_waits();
    int                    errs;
    mem_req_t              wreq;
    mem_wdata_t            wdata;
    l15_req_t              got;
    mem_resp_t             rsp;
    logic [MEM_DATA_W-1:0] bits;
    errs = errors;
    rand_req(MEM_WRITE, 3'd4, 4'd7, wreq);
    rand_bits(MEM_DATA_W, bits);
    wdata.data = bits;
    wdata.be   = '1;
    @(negedge clk_i);
    wreq_valid_i    = 1'b1;
    wreq_i          = wreq;
    wdata_i         = wdata;
    mem_req_ready_i = 1'b1;
    // Request alone must not go out
    repeat (3) begin
      #1;
      check_flag("mem_req_valid_o", mem_req_valid_o, 1'b0);
      check_flag("wreq_ready_o", wreq_ready_o, 1'b0);
      @(negedge clk_i);
    end
    wdata_valid_i = 1'b1;
    mem_accept(got);
    wreq_valid_i  = 1'b0;
    wdata_valid_i = 1'b0;
    check_flag("wreq_ready_o", acc_wreq_rdy, 1'b1);
    check_req("mem_req_o", got, exp_dcache_req(PORT_DWRITE, wreq, wdata));
    rsp         = '0;
    rsp.port_id = PORT_DWRITE;
    rsp.id      = wreq.id;
    rsp.wack    = 1'b1;
    mem_respond(rsp);
    wait_resp(PORT_DWRITE);
    check_resp("dwrite_resp_o", dwrite_resp_o, rsp);
    check_flag("dread_resp_valid_o", dread_resp_valid_o, 1'b0);
    end_test("write waits for data", errs);
  endtask

  task automatic test_round_robin();
    int                    errs;
    icache_miss_t          miss;
    mem_req_t              dreq;
    mem_req_t              wreq;
    mem_wdata_t            wdata;
    l15_req_t              exp_seq [4];
    logic [MEM_DATA_W-1:0] bits;
    errs = errors;
    apply_reset();
    rand_bits(PADDR_W, bits);
    miss.paddr = bits[PADDR_W-1:0];
    miss.nc    = 1'b0;
    miss.tid   = 4'd1;
    rand_req(MEM_READ, 3'd4, 4'd2, dreq);
    rand_req(MEM_WRITE, 3'd4, 4'd3, wreq);
    rand_bits(MEM_DATA_W, bits);
    wdata.data = bits;
    wdata.be   = '1;
    exp_seq[0] = exp_icache_req(miss);
    exp_seq[1] = exp_dcache_req(PORT_DREAD, dreq, '0);
    exp_seq[2] = exp_dcache_req(PORT_DWRITE, wreq, wdata);
    exp_seq[3] = exp_seq[0];
    // Icache miss needs a cycle in its buffer before it reaches the arbiter
    icache_miss_valid_i = 1'b1;
    icache_miss_i       = miss;
    @(negedge clk_i);
    dread_valid_i   = 1'b1;
    dread_req_i     = dreq;
    wreq_valid_i    = 1'b1;
    wdata_valid_i   = 1'b1;
    wreq_i          = wreq;
    wdata_i         = wdata;
    mem_req_ready_i = 1'b1;
    for (int i = 0; i < 4; i++) begin
      #1;
      check_flag("mem_req_valid_o", mem_req_valid_o, 1'b1);
      check_req("mem_req_o", mem_req_o, exp_seq[i]);
      @(negedge clk_i);
    end
    icache_miss_valid_i = 1'b0;
    dread_valid_i       = 1'b0;
    wreq_valid_i        = 1'b0;
    wdata_valid_i       = 1'b0;
    // Drain the miss taken in again at the last grant
    #1;
    while (mem_req_valid_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    mem_req_ready_i = 1'b0;
    end_test("round-robin order", errs);
  endtask

  task automatic test_backpressure();
    int                    errs;
    mem_req_t              dreq;
    mem_req_t              wreq;
    mem_wdata_t            wdata;
    l15_req_t              exp_w;
    l15_req_t              got;
    mem_resp_t             rsp_a;
    mem_resp_t             rsp_b;
    logic [MEM_DATA_W-1:0] bits;
    errs = errors;
    rand_req(MEM_WRITE, 3'd4, 4'd5, wreq);
    rand_req(MEM_READ, 3'd4, 4'd6, dreq);
    rand_bits(MEM_DATA_W, bits);
    wdata.data = bits;
    wdata.be   = '1;
    exp_w      = exp_dcache_req(PORT_DWRITE, wreq, wdata);
    // Write stalls alone, then a read joins and must not take over
    @(negedge clk_i);
    wreq_valid_i  = 1'b1;
    wdata_valid_i = 1'b1;
    wreq_i        = wreq;
    wdata_i       = wdata;
    #1;
    check_req("mem_req_o", mem_req_o, exp_w);
    @(negedge clk_i);
    dread_valid_i = 1'b1;
    dread_req_i   = dreq;
    repeat (4) begin
      #1;
      check_flag("mem_req_valid_o", mem_req_valid_o, 1'b1);
      check_req("mem_req_o", mem_req_o, exp_w);
      @(negedge clk_i);
    end
    mem_accept(got);
    wreq_valid_i  = 1'b0;
    wdata_valid_i = 1'b0;
    check_req("mem_req_o", got, exp_w);
    mem_accept(got);
    dread_valid_i = 1'b0;
    check_req("mem_req_o", got, exp_dcache_req(PORT_DREAD, dreq, '0));

    // Stalled read response blocks a second one
    read_resp(PORT_DREAD, dreq.id, rsp_a);
    rsp_b         = '0;
    rsp_b.port_id = PORT_DWRITE;
    rsp_b.id      = wreq.id;
    rsp_b.wack    = 1'b1;
    dread_resp_ready_i = 1'b0;
    mem_respond(rsp_a);
    @(negedge clk_i);
    mem_resp_valid_i = 1'b1;
    mem_resp_i       = rsp_b;
    repeat (3) begin
      #1;
      check_flag("mem_resp_ready_o", mem_resp_ready_o, 1'b0);
      check_flag("dread_resp_valid_o", dread_resp_valid_o, 1'b1);
      check_resp("dread_resp_o", dread_resp_o, rsp_a);
      @(negedge clk_i);
    end
    dread_resp_ready_i = 1'b1;
    #1;
    check_flag("mem_resp_ready_o", mem_resp_ready_o, 1'b1);
    check_resp("dread_resp_o", dread_resp_o, rsp_a);
    @(negedge clk_i);
    mem_resp_valid_i = 1'b0;
    #1;
    check_flag("dread_resp_valid_o", dread_resp_valid_o, 1'b0);
    check_flag("dwrite_resp_valid_o", dwrite_resp_valid_o, 1'b1);
    check_resp("dwrite_resp_o", dwrite_resp_o, rsp_b);
    end_test("back-pressure", errs);
  endtask

  initial begin
    lfsr_q        = 32'h92f5a82b;
    arst_n_i      = 1'b0;
    icache_miss_i = '0;
    dread_req_i   = '0;
    wreq_i        = '0;
    wdata_i       = '0;
    mem_resp_i    = '0;
    idle_inputs();
    apply_reset();
    test_icache_fill();
    test_dread();
    test_write_waits();
    test_round_robin();
    test_backpressure();
    @(negedge clk_i);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // Half a period high, half low
  always begin
    #(PERIOD_NS / 2);
    clk_o = ~clk_o;
  end

endmodule

// File: source/l15_adapter_top.sv
`timescale 1ns/1ps

module l15_adapter_top import l15_adapter_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,

  // Instruction cache
  input  logic         icache_miss_valid_i,
  output logic         icache_miss_ready_o,
  input  icache_miss_t icache_miss_i,
  output logic         icache_rtrn_valid_o,
  output icache_rtrn_t icache_rtrn_o,

  // Data cache read miss and write buffer
  input  logic         dread_valid_i,
  output logic         dread_ready_o,
  input  mem_req_t     dread_req_i,
  input  logic         wreq_valid_i,
  input  logic         wdata_valid_i,
  output logic         wreq_ready_o,
  input  mem_req_t     wreq_i,
  input  mem_wdata_t   wdata_i,

  output logic         dread_resp_valid_o,
  input  logic         dread_resp_ready_i,
  output mem_resp_t    dread_resp_o,
  output logic         dwrite_resp_valid_o,
  input  logic         dwrite_resp_ready_i,
  output mem_resp_t    dwrite_resp_o,

  // Memory port
  output logic         mem_req_valid_o,
  input  logic         mem_req_ready_i,
  output l15_req_t     mem_req_o,
  input  logic         mem_resp_valid_i,
  output logic         mem_resp_ready_o,
  input  mem_resp_t    mem_resp_i
);

  logic      ic_req_valid;
  logic      ic_req_ready;
  mem_req_t  ic_req;
  logic      ic_resp_valid;
  mem_resp_t ic_resp;
  mem_resp_t dcache_resp;

  icache_miss_port u_icache_miss_port (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .miss_valid_i (icache_miss_valid_i),
    .miss_ready_o (icache_miss_ready_o),
    .miss_i       (icache_miss_i),
    .req_valid_o  (ic_req_valid),
    .req_ready_i  (ic_req_ready),
    .req_o        (ic_req),
    .resp_valid_i (ic_resp_valid),
    .resp_i       (ic_resp),
    .rtrn_valid_o (icache_rtrn_valid_o),
    .rtrn_o       (icache_rtrn_o)
  );

  l15_req_arbiter u_req_arbiter (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .icache_valid_i  (ic_req_valid),
    .icache_ready_o  (ic_req_ready),
    .icache_req_i    (ic_req),
    .dread_valid_i   (dread_valid_i),
    .dread_ready_o   (dread_ready_o),
    .dread_req_i     (dread_req_i),
    .wreq_valid_i    (wreq_valid_i),
    .wdata_valid_i   (wdata_valid_i),
    .wreq_ready_o    (wreq_ready_o),
    .wreq_i          (wreq_i),
    .wdata_i         (wdata_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_o       (mem_req_o)
  );

  l15_resp_demux u_resp_demux (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .resp_valid_i   (mem_resp_valid_i),
    .resp_ready_o   (mem_resp_ready_o),
    .resp_i         (mem_resp_i),
    .icache_valid_o (ic_resp_valid),
    .icache_resp_o  (ic_resp),
    .dread_valid_o  (dread_resp_valid_o),
    .dread_ready_i  (dread_resp_ready_i),
    .dwrite_valid_o (dwrite_resp_valid_o),
    .dwrite_ready_i (dwrite_resp_ready_i),
    .dcache_resp_o  (dcache_resp)
  );

  // Both data cache ports see the same payload, valids tell them apart
  assign dread_resp_o  = dcache_resp;
  assign dwrite_resp_o = dcache_resp;

endmodule

// File: source/l15_resp_demux.sv
`timescale 1ns/1ps

module l15_resp_demux import l15_adapter_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,

  // From the memory port
  input  logic      resp_valid_i,
  output logic      resp_ready_o,
  input  mem_resp_t resp_i,

  // Instruction cache side, never stalls
  output logic      icache_valid_o,
  output mem_resp_t icache_resp_o,

  // Data cache side
  output logic      dread_valid_o,
  input  logic      dread_ready_i,
  output logic      dwrite_valid_o,
  input  logic      dwrite_ready_i,
  output mem_resp_t dcache_resp_o
);

  logic      buf_valid;
  logic      buf_ready;
  mem_resp_t buf_resp;

  one_entry_buffer #(
    .payload_t (mem_resp_t)
  ) u_resp_buf (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (resp_valid_i),
    .in_ready_o  (resp_ready_o),
    .in_data_i   (resp_i),
    .out_valid_o (buf_valid),
    .out_ready_i (buf_ready),
    .out_data_o  (buf_resp)
  );

  // Route by the echoed port tag
  assign icache_valid_o = buf_valid && (buf_resp.port_id == PORT_ICACHE);
  assign dread_valid_o  = buf_valid && (buf_resp.port_id == PORT_DREAD);
  assign dwrite_valid_o = buf_valid && (buf_resp.port_id == PORT_DWRITE);

  always_comb begin
    case (buf_resp.port_id)
      PORT_DREAD:  buf_ready = dread_ready_i;
      PORT_DWRITE: buf_ready = dwrite_ready_i;
      default:     buf_ready = 1'b1;
    endcase
  end

  assign icache_resp_o = buf_resp;
  assign dcache_resp_o = buf_resp;

  a_valid_port: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    buf_valid |-> (int'(buf_resp.port_id) < NUM_PORTS));

endmodule

// File: source/l15_req_arbiter.sv
`timescale 1ns/1ps

module l15_req_arbiter import l15_adapter_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,

  input  logic       icache_valid_i,
  output logic       icache_ready_o,
  input  mem_req_t   icache_req_i,

  input  logic       dread_valid_i,
  output logic       dread_ready_o,
  input  mem_req_t   dread_req_i,

  input  logic       wreq_valid_i,
  input  logic       wdata_valid_i,
  output logic       wreq_ready_o,
  input  mem_req_t   wreq_i,
  input  mem_wdata_t wdata_i,

  output logic       mem_req_valid_o,
  input  logic       mem_req_ready_i,
  output l15_req_t   mem_req_o
);

  logic [NUM_PORTS-1:0] req_vld;
  port_id_t             rr_ptr_q;
  port_id_t             pick_id;
  port_id_t             gnt_id;
  logic                 lock_q;
  port_id_t             lock_id_q;
  logic                 xfer;

  // Write counts only once its data beat is there too
  assign req_vld[PORT_ICACHE] = icache_valid_i;
  assign req_vld[PORT_DREAD]  = dread_valid_i;
  assign req_vld[PORT_DWRITE] = wreq_valid_i & wdata_valid_i;

  // First requester at or after the pointer, lowest offset wins
  always_comb begin
    pick_id = rr_ptr_q;
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      if (req_vld[(int'(rr_ptr_q) + i) % NUM_PORTS]) begin
        pick_id = port_id_t'((int'(rr_ptr_q) + i) % NUM_PORTS);
      end
    end
  end

  // A stalled grant is kept until the memory takes it
  assign gnt_id          = lock_q ? lock_id_q : pick_id;
  assign mem_req_valid_o = req_vld[gnt_id];
  assign xfer            = mem_req_valid_o & mem_req_ready_i;

  assign icache_ready_o = xfer && (gnt_id == PORT_ICACHE);
  assign dread_ready_o  = xfer && (gnt_id == PORT_DREAD);
  assign wreq_ready_o   = xfer && (gnt_id == PORT_DWRITE);

  always_comb begin
    mem_req_o.port_id = gnt_id;
    mem_req_o.wdata   = '0;
    case (gnt_id)
      PORT_DREAD:  mem_req_o.req = dread_req_i;
      PORT_DWRITE: begin
        mem_req_o.req   = wreq_i;
        mem_req_o.wdata = wdata_i;
      end
      default:     mem_req_o.req = icache_req_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q  <= PORT_ICACHE;
      lock_q    <= 1'b0;
      lock_id_q <= PORT_ICACHE;
    end else begin
      if (xfer) begin
        rr_ptr_q <= (gnt_id == port_id_t'(NUM_PORTS - 1)) ? PORT_ICACHE : gnt_id + 2'd1;
      end
      lock_q <= mem_req_valid_o & ~mem_req_ready_i;
      if (mem_req_valid_o) begin
        lock_id_q <= gnt_id;
      end
    end
  end

  a_one_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({icache_ready_o, dread_ready_o, wreq_ready_o}));

  // Sources hold their payload, so a stalled request must not change
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

// File: source/icache_miss_port.sv
`timescale 1ns/1ps

module icache_miss_port import l15_adapter_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,

  // Miss from the instruction cache
  input  logic         miss_valid_i,
  output logic         miss_ready_o,
  input  icache_miss_t miss_i,

  // Buffered read towards the arbiter
  output logic         req_valid_o,
  input  logic         req_ready_i,
  output mem_req_t     req_o,

  // Routed response and fill return
  input  logic         resp_valid_i,
  input  mem_resp_t    resp_i,
  output logic         rtrn_valid_o,
  output icache_rtrn_t rtrn_o
);

  mem_req_t miss_req;

  // Non-cacheable fetches read a single word
  assign miss_req.addr      = miss_i.paddr;
  assign miss_req.size      = miss_i.nc ? 3'(ICACHE_WORD_SIZE) : 3'(ICACHE_LINE_SIZE);
  assign miss_req.id        = miss_i.tid;
  assign miss_req.cmd       = MEM_READ;
  assign miss_req.cacheable = ~miss_i.nc;

  // Decouples the cache from the arbiter and cuts the ready path
  one_entry_buffer #(
    .payload_t (mem_req_t)
  ) u_miss_buf (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (miss_valid_i),
    .in_ready_o  (miss_ready_o),
    .in_data_i   (miss_req),
    .out_valid_o (req_valid_o),
    .out_ready_i (req_ready_i),
    .out_data_o  (req_o)
  );

  // The cache always takes a return, so valid passes straight through
  assign rtrn_valid_o = resp_valid_i;
  assign rtrn_o.rtype = ICACHE_IFILL_ACK;
  assign rtrn_o.data  = resp_i.data;
  assign rtrn_o.tid   = resp_i.id;

endmodule

// File: source/one_entry_buffer.sv
`timescale 1ns/1ps

module one_entry_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,

  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,

  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     full_q;
  payload_t data_q;
  logic     push;

  // Accept when empty or when the held item leaves this cycle
  assign in_ready_o  = ~full_q | out_ready_i;
  assign push        = in_valid_i & in_ready_o;
  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q <= in_data_i;
    end
  end

  // Item must not change under a stalled consumer
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    full_q && !out_ready_i |=> full_q && $stable(data_q));

endmodule

// File: source/l15_adapter_pkg.sv
package l15_adapter_pkg;

  // Widths of the memory port
  localparam int PADDR_W    = 40;
  localparam int MEM_DATA_W = 128;
  localparam int MEM_BE_W   = 16;
  localparam int MEM_ID_W   = 4;

  // Request sources, also used as the response routing tag
  localparam int NUM_PORTS = 3;
  typedef logic [1:0] port_id_t;
  localparam port_id_t PORT_ICACHE = 2'd0;
  localparam port_id_t PORT_DREAD  = 2'd1;
  localparam port_id_t PORT_DWRITE = 2'd2;

  // Log2 of the request size in bytes
  localparam int ICACHE_WORD_SIZE = 3;
  localparam int ICACHE_LINE_SIZE = 4;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_cmd_e;

  typedef struct packed {
    logic [PADDR_W-1:0]  addr;
    logic [2:0]          size;
    logic [MEM_ID_W-1:0] id;
    mem_cmd_e            cmd;
    logic                cacheable;
  } mem_req_t;

  typedef struct packed {
    logic [MEM_DATA_W-1:0] data;
    logic [MEM_BE_W-1:0]   be;
  } mem_wdata_t;

  // What leaves on the memory port
  typedef struct packed {
    port_id_t   port_id;
    mem_req_t   req;
    mem_wdata_t wdata;
  } l15_req_t;

  typedef struct packed {
    port_id_t              port_id;
    logic [MEM_ID_W-1:0]   id;
    logic [MEM_DATA_W-1:0] data;
    logic                  error;
    logic                  wack;
  } mem_resp_t;

  typedef struct packed {
    logic [PADDR_W-1:0]  paddr;
    logic                nc;
    logic [MEM_ID_W-1:0] tid;
  } icache_miss_t;

  // Fill ack is the only return type left
  typedef enum logic {
    ICACHE_IFILL_ACK = 1'b0
  } icache_rtrn_e;

  typedef struct packed {
    icache_rtrn_e          rtype;
    logic [MEM_DATA_W-1:0] data;
    logic [MEM_ID_W-1:0]   tid;
  } icache_rtrn_t;

endpackage
